//--- logic/core_pkg.sv
// Compute core shared types
`default_nettype none

package core_pkg;

    // Word widths fixed by the instruction set
    typedef logic [7:0]  data_t;
    typedef logic [15:0] instr_t;
    typedef logic [7:0]  pc_t;
    typedef logic [3:0]  reg_idx_t;

    // Bit 2 is greater than, bit 1 is equal, bit 0 is less than
    typedef logic [2:0]  nzp_t;

    // Opcodes live in instruction bits 15 to 12
    typedef enum logic [3:0] {
        OP_NOP   = 4'd0,
        OP_BRNZP = 4'd1,
        OP_CMP   = 4'd2,
        OP_ADD   = 4'd3,
        OP_SUB   = 4'd4,
        OP_MUL   = 4'd5,
        OP_DIV   = 4'd6,
        OP_STR   = 4'd8,
        OP_CONST = 4'd9,
        OP_RET   = 4'd15
    } opcode_t;

    // Scheduler states with EXECUTE at 5 and UPDATE at 6
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        FETCH   = 3'd1,
        DECODE  = 3'd2,
        REQUEST = 3'd3,
        WAIT    = 3'd4,
        EXECUTE = 3'd5,
        UPDATE  = 3'd6,
        DONE    = 3'd7
    } core_state_t;

    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_MUL = 2'd2,
        ALU_DIV = 2'd3
    } alu_op_t;

endpackage

`default_nettype wire

//--- logic/decoded_if.sv
// Decoded control bundle
`timescale 1ns/1ps
`default_nettype none

interface decoded_if;

    // Register indices and the immediate byte
    core_pkg::reg_idx_t rd;
    core_pkg::reg_idx_t rs;
    core_pkg::reg_idx_t rt;
    core_pkg::data_t    immediate;
    core_pkg::nzp_t     nzp;

    // Control bits set from the opcode
    core_pkg::alu_op_t  alu_op;
    logic               alu_select_cmp;
    logic               reg_write_enable;
    // High selects the immediate, low the ALU result
    logic               reg_input_select;
    logic               nzp_write_enable;
    logic               pc_branch;
    logic               mem_write_enable;
    logic               ret;

    modport producer (
        output rd, rs, rt, immediate, nzp, alu_op, alu_select_cmp, reg_write_enable,
               reg_input_select, nzp_write_enable, pc_branch, mem_write_enable, ret
    );

    modport consumer (
        input rd, rs, rt, immediate, nzp, alu_op, alu_select_cmp, reg_write_enable,
              reg_input_select, nzp_write_enable, pc_branch, mem_write_enable, ret
    );

endinterface

`default_nettype wire

//--- logic/core_scheduler.sv
// Core scheduler
`timescale 1ns/1ps
`default_nettype none

module core_scheduler (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  start,
    decoded_if.consumer           decoded,
    input  logic                  fetch_done,
    input  core_pkg::pc_t         next_pc,
    input  core_pkg::data_t       rs_value,
    input  core_pkg::data_t       rt_value,
    output logic                  data_mem_write_req,
    input  logic                  data_mem_write_ack,
    output core_pkg::data_t       data_mem_write_address,
    output core_pkg::data_t       data_mem_write_data,
    output core_pkg::core_state_t core_state,
    output core_pkg::pc_t         current_pc,
    output logic                  done
);

    // DONE only leaves on reset, so done holds high until then
    assign done = (core_state == core_pkg::DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            core_state         <= core_pkg::IDLE;
            current_pc         <= '0;
            data_mem_write_req <= 1'b0;
        end else begin
            case (core_state)
                core_pkg::IDLE: begin
                    // Programs always begin at address 0
                    if (start) begin
                        current_pc <= '0;
                        core_state <= core_pkg::FETCH;
                    end
                end
                core_pkg::FETCH: begin
                    if (fetch_done) begin
                        core_state <= core_pkg::DECODE;
                    end
                end
                core_pkg::DECODE: begin
                    core_state <= core_pkg::REQUEST;
                end
                core_pkg::REQUEST: begin
                    // Only a store opens a data memory handshake
                    if (decoded.mem_write_enable) begin
                        data_mem_write_req <= 1'b1;
                    end
                    core_state <= core_pkg::WAIT;
                end
                core_pkg::WAIT: begin
                    // Drop the request once memory has seen it
                    if (data_mem_write_req && data_mem_write_ack) begin
                        data_mem_write_req <= 1'b0;
                    end
                    // Both low means no store, or the store handshake is complete
                    if (!data_mem_write_req && !data_mem_write_ack) begin
                        core_state <= core_pkg::EXECUTE;
                    end
                end
                core_pkg::EXECUTE: begin
                    core_state <= core_pkg::UPDATE;
                end
                core_pkg::UPDATE: begin
                    if (decoded.ret) begin
                        core_state <= core_pkg::DONE;
                    end else begin
                        current_pc <= next_pc;
                        core_state <= core_pkg::FETCH;
                    end
                end
                default: begin
                    core_state <= core_pkg::DONE;
                end
            endcase
        end
    end

    // The store address comes from rs and the stored byte from rt
    always_ff @(posedge clk) begin
        if (core_state == core_pkg::REQUEST && decoded.mem_write_enable) begin
            data_mem_write_address <= rs_value;
            data_mem_write_data    <= rt_value;
        end
    end

endmodule

`default_nettype wire

//--- logic/instruction_fetcher.sv
// Instruction fetcher
`timescale 1ns/1ps
`default_nettype none

module instruction_fetcher (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::core_state_t core_state,
    input  core_pkg::pc_t         current_pc,
    output logic                  program_mem_read_req,
    output core_pkg::pc_t         program_mem_read_address,
    input  logic                  program_mem_read_ack,
    input  core_pkg::instr_t      program_mem_read_data,
    output core_pkg::instr_t      instruction,
    output logic                  fetch_done
);

    typedef enum logic [1:0] {
        FETCH_IDLE    = 2'd0,
        FETCH_REQUEST = 2'd1,
        FETCH_RELEASE = 2'd2,
        FETCH_HOLD    = 2'd3
    } fetch_state_t;

    fetch_state_t fetch_state;

    // The PC only moves in UPDATE, so the address is stable for the whole handshake
    assign program_mem_read_address = current_pc;
    assign fetch_done = (fetch_state == FETCH_HOLD);

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_state          <= FETCH_IDLE;
            program_mem_read_req <= 1'b0;
        end else begin
            case (fetch_state)
                FETCH_IDLE: begin
                    if (core_state == core_pkg::FETCH) begin
                        program_mem_read_req <= 1'b1;
                        fetch_state          <= FETCH_REQUEST;
                    end
                end
                FETCH_REQUEST: begin
                    if (program_mem_read_ack) begin
                        program_mem_read_req <= 1'b0;
                        fetch_state          <= FETCH_RELEASE;
                    end
                end
                FETCH_RELEASE: begin
                    // Finish only after memory has dropped its acknowledge
                    if (!program_mem_read_ack) begin
                        fetch_state <= FETCH_HOLD;
                    end
                end
                default: begin
                    // Hold the word until the scheduler has left FETCH
                    if (core_state != core_pkg::FETCH) begin
                        fetch_state <= FETCH_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_state == FETCH_REQUEST && program_mem_read_ack) begin
            instruction <= program_mem_read_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/instruction_decoder.sv
// Instruction decoder
`timescale 1ns/1ps
`default_nettype none

module instruction_decoder (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::core_state_t core_state,
    input  core_pkg::instr_t      instruction,
    decoded_if.producer           decoded
);

    always_ff @(posedge clk) begin
        if (reset) begin
            decoded.alu_op           <= core_pkg::ALU_ADD;
            decoded.alu_select_cmp   <= 1'b0;
            decoded.reg_write_enable <= 1'b0;
            decoded.reg_input_select <= 1'b0;
            decoded.nzp_write_enable <= 1'b0;
            decoded.pc_branch        <= 1'b0;
            decoded.mem_write_enable <= 1'b0;
            decoded.ret              <= 1'b0;
        end else if (core_state == core_pkg::DECODE) begin
            // Clear every control bit so that NOP and unknown opcodes do nothing
            decoded.alu_op           <= core_pkg::ALU_ADD;
            decoded.alu_select_cmp   <= 1'b0;
            decoded.reg_write_enable <= 1'b0;
            decoded.reg_input_select <= 1'b0;
            decoded.nzp_write_enable <= 1'b0;
            decoded.pc_branch        <= 1'b0;
            decoded.mem_write_enable <= 1'b0;
            decoded.ret              <= 1'b0;
            case (core_pkg::opcode_t'(instruction[15:12]))
                core_pkg::OP_BRNZP: decoded.pc_branch <= 1'b1;
                core_pkg::OP_CMP: begin
                    decoded.alu_select_cmp   <= 1'b1;
                    decoded.nzp_write_enable <= 1'b1;
                end
                core_pkg::OP_ADD: begin
                    decoded.alu_op           <= core_pkg::ALU_ADD;
                    decoded.reg_write_enable <= 1'b1;
                end
                core_pkg::OP_SUB: begin
                    decoded.alu_op           <= core_pkg::ALU_SUB;
                    decoded.reg_write_enable <= 1'b1;
                end
                core_pkg::OP_MUL: begin
                    decoded.alu_op           <= core_pkg::ALU_MUL;
                    decoded.reg_write_enable <= 1'b1;
                end
                core_pkg::OP_DIV: begin
                    decoded.alu_op           <= core_pkg::ALU_DIV;
                    decoded.reg_write_enable <= 1'b1;
                end
                core_pkg::OP_STR: decoded.mem_write_enable <= 1'b1;
                core_pkg::OP_CONST: begin
                    decoded.reg_write_enable <= 1'b1;
                    decoded.reg_input_select <= 1'b1;
                end
                core_pkg::OP_RET: decoded.ret <= 1'b1;
                default: ;
            endcase
        end
    end

    // The operand fields and the immediate are taken straight from the instruction word
    always_ff @(posedge clk) begin
        if (core_state == core_pkg::DECODE) begin
            decoded.rd        <= instruction[11:8];
            decoded.rs        <= instruction[7:4];
            decoded.rt        <= instruction[3:0];
            decoded.immediate <= instruction[7:0];
            // The branch mask sits in the upper three bits of the rd field
            decoded.nzp       <= instruction[11:9];
        end
    end

endmodule

`default_nettype wire

//--- logic/register_file.sv
// Register file
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::core_state_t core_state,
    decoded_if.consumer           decoded,
    input  core_pkg::data_t       alu_result,
    output core_pkg::data_t       rs_value,
    output core_pkg::data_t       rt_value
);

    core_pkg::data_t registers [16];

    // Reads are combinational and follow the decoded indices
    assign rs_value = registers[decoded.rs];
    assign rt_value = registers[decoded.rt];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                registers[i] <= '0;
            end
        end else if (core_state == core_pkg::UPDATE && decoded.reg_write_enable) begin
            // CONST writes its immediate and arithmetic writes the ALU result
            if (decoded.reg_input_select) begin
                registers[decoded.rd] <= decoded.immediate;
            end else begin
                registers[decoded.rd] <= alu_result;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/alu.sv
// Arithmetic and compare unit
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::core_state_t core_state,
    decoded_if.consumer           decoded,
    input  core_pkg::data_t       rs_value,
    input  core_pkg::data_t       rt_value,
    output core_pkg::data_t       alu_result
);

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_result <= '0;
        end else if (core_state == core_pkg::EXECUTE) begin
            if (decoded.alu_select_cmp) begin
                // Flags go in the NZP order of greater, equal and less
                alu_result <= {5'b0, rs_value > rt_value, rs_value == rt_value,
                               rs_value < rt_value};
            end else begin
                // Eight-bit results wrap modulo 256
                case (decoded.alu_op)
                    core_pkg::ALU_ADD: alu_result <= rs_value + rt_value;
                    core_pkg::ALU_SUB: alu_result <= rs_value - rt_value;
                    core_pkg::ALU_MUL: alu_result <= rs_value * rt_value;
                    default: begin
                        // Dividing by zero gives 0
                        if (rt_value == '0) begin
                            alu_result <= '0;
                        end else begin
                            alu_result <= rs_value / rt_value;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/program_counter.sv
// Program counter and NZP register
`timescale 1ns/1ps
`default_nettype none

module program_counter (
    input  logic                  clk,
    input  logic                  reset,
    input  core_pkg::core_state_t core_state,
    decoded_if.consumer           decoded,
    input  core_pkg::data_t       alu_result,
    input  core_pkg::pc_t         current_pc,
    output core_pkg::pc_t         next_pc
);

    core_pkg::nzp_t nzp;
    logic           active;

    // Stands in for the per-thread enable and is high between start and done
    assign active = (core_state != core_pkg::IDLE) && (core_state != core_pkg::DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            nzp     <= '0;
            next_pc <= '0;
        end else if (active) begin
            // Branch only when the mask hits a flag left by an earlier CMP
            if (core_state == core_pkg::EXECUTE) begin
                if (decoded.pc_branch && (nzp & decoded.nzp) != '0) begin
                    next_pc <= decoded.immediate;
                end else begin
                    next_pc <= current_pc + 1'b1;
                end
            end
            // The compare flags land in the low three ALU bits
            if (core_state == core_pkg::UPDATE && decoded.nzp_write_enable) begin
                nzp <= alu_result[2:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/compute_core.sv
// Compute core top level
`timescale 1ns/1ps
`default_nettype none

module compute_core (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    output logic             done,
    // Program memory read port
    output logic             program_mem_read_req,
    output core_pkg::pc_t    program_mem_read_address,
    input  logic             program_mem_read_ack,
    input  core_pkg::instr_t program_mem_read_data,
    // Data memory write port
    output logic             data_mem_write_req,
    output core_pkg::data_t  data_mem_write_address,
    output core_pkg::data_t  data_mem_write_data,
    input  logic             data_mem_write_ack
);

    core_pkg::core_state_t core_state;
    core_pkg::pc_t         current_pc;
    core_pkg::pc_t         next_pc;
    core_pkg::instr_t      instruction;
    core_pkg::data_t       rs_value;
    core_pkg::data_t       rt_value;
    core_pkg::data_t       alu_result;
    logic                  fetch_done;

    decoded_if decoded ();

    core_scheduler u_scheduler (
        .clk                    (clk),
        .reset                  (reset),
        .start                  (start),
        .decoded                (decoded.consumer),
        .fetch_done             (fetch_done),
        .next_pc                (next_pc),
        .rs_value               (rs_value),
        .rt_value               (rt_value),
        .data_mem_write_req     (data_mem_write_req),
        .data_mem_write_ack     (data_mem_write_ack),
        .data_mem_write_address (data_mem_write_address),
        .data_mem_write_data    (data_mem_write_data),
        .core_state             (core_state),
        .current_pc             (current_pc),
        .done                   (done)
    );

    instruction_fetcher u_fetcher (
        .clk                      (clk),
        .reset                    (reset),
        .core_state               (core_state),
        .current_pc               (current_pc),
        .program_mem_read_req     (program_mem_read_req),
        .program_mem_read_address (program_mem_read_address),
        .program_mem_read_ack     (program_mem_read_ack),
        .program_mem_read_data    (program_mem_read_data),
        .instruction              (instruction),
        .fetch_done               (fetch_done)
    );

    instruction_decoder u_decoder (
        .clk         (clk),
        .reset       (reset),
        .core_state  (core_state),
        .instruction (instruction),
        .decoded     (decoded.producer)
    );

    register_file u_register_file (
        .clk        (clk),
        .reset      (reset),
        .core_state (core_state),
        .decoded    (decoded.consumer),
        .alu_result (alu_result),
        .rs_value   (rs_value),
        .rt_value   (rt_value)
    );

    alu u_alu (
        .clk        (clk),
        .reset      (reset),
        .core_state (core_state),
        .decoded    (decoded.consumer),
        .rs_value   (rs_value),
        .rt_value   (rt_value),
        .alu_result (alu_result)
    );

    program_counter u_program_counter (
        .clk        (clk),
        .reset      (reset),
        .core_state (core_state),
        .decoded    (decoded.consumer),
        .alu_result (alu_result),
        .current_pc (current_pc),
        .next_pc    (next_pc)
    );

endmodule

`default_nettype wire

//--- test/compute_core_tb.sv
// Compute core testbench
`timescale 1ns/1ps
`default_nettype none

module compute_core_tb;

    localparam int NUM_TESTS    = 6;
    localparam int PROG_WORDS   = 16;
    localparam int MAX_STORES   = 5;
    localparam int WATCH_CYCLES = 16;

    // Opcodes in the hand-assembled programs are 9 CONST rd imm, 8 STR [rs] rt, 3 ADD, 4 SUB
    // 5 MUL, 6 DIV, 2 CMP rs rt, 1 BR with the mask in bits 11 to 9 and F RET
    localparam logic [15:0] PROGRAMS [NUM_TESTS][PROG_WORDS] = '{
        '{16'h9107, 16'h922A, 16'h8012, 16'hF000, 16'h0000, 16'h0000, 16'h0000, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h91C8, 16'h9264, 16'h9303, 16'h9405, 16'h9500, 16'h3612, 16'h4734, 16'h5813,
          16'h6914, 16'h8036, 16'h8047, 16'h8028, 16'h8019, 16'h6215, 16'h8052, 16'hF000},
        '{16'h9105, 16'h9203, 16'h9340, 16'h9541, 16'h2012, 16'h1208, 16'h94AA, 16'h8034,
          16'h180B, 16'h96BB, 16'hF000, 16'h8056, 16'hF000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h9103, 16'h9201, 16'h9300, 16'h9450, 16'h8041, 16'h4112, 16'h3442, 16'h2013,
          16'h1804, 16'hF000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h9177, 16'h8011, 16'hF000, 16'h9160, 16'h8011, 16'hF000, 16'h0000, 16'h0000,
          16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h9103, 16'h9201, 16'h9300, 16'h9450, 16'h8041, 16'h4112, 16'h3442, 16'h2013,
          16'h1804, 16'hF000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000, 16'h0000}
    };

    // Expected stores with the address in the high byte and the data in the low byte
    localparam logic [15:0] EXP_STORES [NUM_TESTS][MAX_STORES] = '{
        '{16'h072A, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h032C, 16'h05FE, 16'h6458, 16'hC828, 16'h0000},
        '{16'h40AA, 16'h4100, 16'h0000, 16'h0000, 16'h0000},
        '{16'h5003, 16'h5102, 16'h5201, 16'h0000, 16'h0000},
        '{16'h7777, 16'h0000, 16'h0000, 16'h0000, 16'h0000},
        '{16'h5003, 16'h5102, 16'h5201, 16'h0000, 16'h0000}
    };
    localparam int EXP_COUNT [NUM_TESTS] = '{1, 5, 2, 3, 1, 3};
    // Instructions executed per test counted by hand with the loop passes included
    localparam int STEPS [NUM_TESTS] = '{4, 16, 11, 20, 3, 20};
    // Mask on the random acknowledge delay where 3 gives 0 to 3 cycles
    localparam int DELAY_MASK [NUM_TESTS] = '{3, 0, 3, 0, 3, 3};

    string test_names [NUM_TESTS] = '{"const_store", "arith_wrap", "cmp_branch",
                                      "countdown_loop", "ret_done", "countdown_slow"};

    logic             clk;
    logic             reset;
    logic             start;
    logic             done;
    logic             program_mem_read_req;
    core_pkg::pc_t    program_mem_read_address;
    logic             program_mem_read_ack = 1'b0;
    core_pkg::instr_t program_mem_read_data = '0;
    logic             data_mem_write_req;
    core_pkg::data_t  data_mem_write_address;
    core_pkg::data_t  data_mem_write_data;
    logic             data_mem_write_ack = 1'b0;

    core_pkg::instr_t program_mem [256];
    // Every completed store, in order, across all tests
    logic [15:0]      store_log [$];

    int seed = 32'h7e7b;
    int ack_mask = 0;
    int prog_delay = 0;
    int data_delay = 0;
    logic prog_armed = 1'b0;
    logic data_armed = 1'b0;
    int cycle_count = 0;
    int timeout_limit = 200;
    int pass_count = 0;
    int fail_count = 0;

    compute_core DUT (
        .clk                      (clk),
        .reset                    (reset),
        .start                    (start),
        .done                     (done),
        .program_mem_read_req     (program_mem_read_req),
        .program_mem_read_address (program_mem_read_address),
        .program_mem_read_ack     (program_mem_read_ack),
        .program_mem_read_data    (program_mem_read_data),
        .data_mem_write_req       (data_mem_write_req),
        .data_mem_write_address   (data_mem_write_address),
        .data_mem_write_data      (data_mem_write_data),
        .data_mem_write_ack       (data_mem_write_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Both memory models answer on the falling edge after a random delay
    always @(negedge clk) begin
        if (reset) begin
            program_mem_read_ack = 1'b0;
            data_mem_write_ack   = 1'b0;
            prog_armed           = 1'b0;
            data_armed           = 1'b0;
        end else begin
            if (program_mem_read_req && !program_mem_read_ack) begin
                if (!prog_armed) begin
                    prog_delay = $random(seed) & ack_mask;
                    prog_armed = 1'b1;
                end
                if (prog_delay == 0) begin
                    program_mem_read_data = program_mem[program_mem_read_address];
                    program_mem_read_ack  = 1'b1;
                    prog_armed            = 1'b0;
                end else begin
                    prog_delay--;
                end
            end else if (!program_mem_read_req && program_mem_read_ack) begin
                program_mem_read_ack = 1'b0;
            end
            // A store is logged at the moment memory acknowledges it
            if (data_mem_write_req && !data_mem_write_ack) begin
                if (!data_armed) begin
                    data_delay = $random(seed) & ack_mask;
                    data_armed = 1'b1;
                end
                if (data_delay == 0) begin
                    store_log.push_back({data_mem_write_address, data_mem_write_data});
                    data_mem_write_ack = 1'b1;
                    data_armed         = 1'b0;
                end else begin
                    data_delay--;
                end
            end else if (!data_mem_write_req && data_mem_write_ack) begin
                data_mem_write_ack = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("test failed");
            $finish;
        end
    end

    // Loads one program, runs it to done and checks the stores it made
    task automatic run_test(input int t);
        int errors;
        int log_base;
        int actual_count;
        errors = 0;
        @(negedge clk);
        reset    = 1'b1;
        ack_mask = DELAY_MASK[t];
        // Addresses past the program hold NOPs that carry their own address
        for (int a = 0; a < 256; a++) begin
            if (a < PROG_WORDS) begin
                program_mem[a] = PROGRAMS[t][a];
            end else begin
                program_mem[a] = {8'h00, 8'(a)};
            end
        end
        repeat (10) @(negedge clk);
        reset    = 1'b0;
        log_base = store_log.size();
        @(negedge clk);
        assert (!done && !program_mem_read_req && !data_mem_write_req) else begin
            $display("%s: outputs not low after reset", test_names[t]);
            errors++;
        end
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
        // After RET the core must stay done and stop fetching
        repeat (WATCH_CYCLES) begin
            @(negedge clk);
            assert (done) else begin
                $display("%s: done dropped before reset", test_names[t]);
                errors++;
            end
            assert (!program_mem_read_req) else begin
                $display("%s: program memory was read after done", test_names[t]);
                errors++;
            end
        end
        actual_count = store_log.size() - log_base;
        assert (actual_count == EXP_COUNT[t]) else begin
            $display("[ERROR] %s store count: expected %0d, actual %0d",
                     test_names[t], EXP_COUNT[t], actual_count);
            errors++;
        end
        for (int i = 0; i < EXP_COUNT[t] && i < actual_count; i++) begin
            assert (store_log[log_base + i] == EXP_STORES[t][i]) else begin
                $display("[ERROR] %s store %0d: expected %h, actual %h", test_names[t], i,
                         EXP_STORES[t][i], store_log[log_base + i]);
                errors++;
            end
        end
        if (errors == 0) begin
            pass_count++;
            $display("PASS %s: %0d stores", test_names[t], actual_count);
        end else begin
            fail_count++;
            $display("FAIL %s: %0d checks failed", test_names[t], errors);
        end
    endtask

    initial begin
        reset = 1'b1;
        start = 1'b0;
        // Twenty cycles cover the slowest instruction and 200 cover the resets and watch windows
        for (int t = 0; t < NUM_TESTS; t++) begin
            timeout_limit += STEPS[t] * 20;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("summary: %0d run, %0d passed, %0d failed", NUM_TESTS, pass_count, fail_count);
        if (fail_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
logic/core_pkg.sv
logic/decoded_if.sv
logic/core_scheduler.sv
logic/instruction_fetcher.sv
logic/instruction_decoder.sv
logic/register_file.sv
logic/alu.sv
logic/program_counter.sv
logic/compute_core.sv
test/compute_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= compute_core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
